// File: design/decodeStage.sv
// Register file with write bypass, control decode and ID/EX register
`timescale 1ns/100ps

module decodeStage (
	input logic Clk,
	input logic rst,
	input logic stall,
	input logic [mipsPkg::DataWidth-1:0] ifIdInstr,
	input mipsPkg::wbT wb,
	output mipsPkg::idExT idEx
);

	// Instruction fields
	mipsPkg::opcodeE opcode;
	mipsPkg::functE funct;
	logic [mipsPkg::RegAddrWidth-1:0] rs;
	logic [mipsPkg::RegAddrWidth-1:0] rt;
	logic [mipsPkg::RegAddrWidth-1:0] rd;
	logic [mipsPkg::RegAddrWidth-1:0] dest;
	logic [mipsPkg::DataWidth-1:0] imm;

	// Register file and its read ports
	logic [mipsPkg::DataWidth-1:0] regs [mipsPkg::NumRegs];
	logic [mipsPkg::DataWidth-1:0] readData1;
	logic [mipsPkg::DataWidth-1:0] readData2;

	// Decoded control
	mipsPkg::ctrlT ctrl;
	logic known;

	assign opcode = mipsPkg::opcodeE'(ifIdInstr[31:26]);
	assign funct = mipsPkg::functE'(ifIdInstr[5:0]);
	assign rs = ifIdInstr[25:21];
	assign rt = ifIdInstr[20:16];
	assign rd = ifIdInstr[15:11];
	assign imm = {{(mipsPkg::DataWidth-16){ifIdInstr[15]}}, ifIdInstr[15:0]};

	// rd for R-type, rt for immediate forms
	assign dest = (opcode == mipsPkg::opRType) ? rd : rt;

	// Writeback port, r0 is never written
	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < mipsPkg::NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.regAddr] <= wb.data;
		end
	end

	// Same-cycle writeback goes straight to the reads
	assign readData1 = (wb.valid && wb.regAddr == rs) ? wb.data : regs[rs];
	assign readData2 = (wb.valid && wb.regAddr == rt) ? wb.data : regs[rt];

	// Control decode
	// Unknown opcodes and functions leave control at zero
	always_comb begin
		ctrl = '0;
		known = 1'b0;
		case (opcode)
			mipsPkg::opRType: begin
				known = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
					default: begin
						// Includes the all-zero word
						known = 1'b0;
						ctrl.regWrite = 1'b0;
					end
				endcase
			end
			mipsPkg::opAddi: begin
				known = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			mipsPkg::opLw: begin
				known = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			mipsPkg::opSw: begin
				known = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			default: begin
				known = 1'b0;
			end
		endcase
		// Drop writes to r0 here so later stages need no check
		if (dest == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

	// ID/EX register
	// Stall loads a bubble with zero control
	always_ff @(posedge Clk) begin
		if (rst) begin
			idEx.valid <= 1'b0;
			idEx.ctrl <= '0;
		end else begin
			idEx.valid <= known && !stall;
			idEx.ctrl <= stall ? '0 : ctrl;
		end
		idEx.readData1 <= readData1;
		idEx.readData2 <= readData2;
		idEx.imm <= imm;
		idEx.rs <= rs;
		idEx.rt <= rt;
		idEx.dest <= dest;
	end

endmodule

// File: design/executeStage.sv
// Operand forwarding, ALU source select, ALU and EX/MEM register
`timescale 1ns/100ps

module executeStage (
	input logic Clk,
	input logic rst,
	input mipsPkg::idExT idEx,
	input mipsPkg::fwdSelE fwdA,
	input mipsPkg::fwdSelE fwdB,
	// Read back for the EX/MEM forwarding path
	output mipsPkg::exMemT exMem,
	input mipsPkg::wbT wb
);

	logic [mipsPkg::DataWidth-1:0] opA;
	logic [mipsPkg::DataWidth-1:0] opB;
	logic [mipsPkg::DataWidth-1:0] aluB;
	logic [mipsPkg::DataWidth-1:0] aluResult;
	logic lessThan;

	// rs operand
	always_comb begin
		case (fwdA)
			mipsPkg::fwdMem: opA = exMem.aluResult;
			mipsPkg::fwdWb: opA = wb.data;
			default: opA = idEx.readData1;
		endcase
	end

	// rt operand, also the store data
	always_comb begin
		case (fwdB)
			mipsPkg::fwdMem: opB = exMem.aluResult;
			mipsPkg::fwdWb: opB = wb.data;
			default: opB = idEx.readData2;
		endcase
	end

	// Immediate for addi, lw and sw
	assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

	// Two's complement compare for slt
	assign lessThan = $signed(opA) < $signed(aluB);

	always_comb begin
		case (idEx.ctrl.aluOp)
			mipsPkg::aluAdd: aluResult = opA + aluB;
			mipsPkg::aluSub: aluResult = opA - aluB;
			mipsPkg::aluAnd: aluResult = opA & aluB;
			mipsPkg::aluOr: aluResult = opA | aluB;
			mipsPkg::aluSlt: aluResult = {{(mipsPkg::DataWidth-1){1'b0}}, lessThan};
			default: aluResult = '0;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge Clk) begin
		if (rst) begin
			exMem.valid <= 1'b0;
			exMem.ctrl <= '0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.ctrl <= idEx.ctrl;
		end
		exMem.aluResult <= aluResult;
		// Forwarded value so a store sees a just-computed register
		exMem.storeData <= opB;
		exMem.dest <= idEx.dest;
	end

endmodule

// File: design/fetchStage.sv
// Program counter and IF/ID instruction register
`timescale 1ns/100ps

module fetchStage (
	input logic Clk,
	input logic rst,
	input logic stall,
	output logic [mipsPkg::DataWidth-1:0] fetchAddr,
	input logic [mipsPkg::DataWidth-1:0] instr,
	output logic [mipsPkg::DataWidth-1:0] ifIdInstr
);

	logic [mipsPkg::DataWidth-1:0] pc;

	// Byte address of the word being fetched
	assign fetchAddr = pc;

	// Straight-line code only, so next PC is always pc + 4
	always_ff @(posedge Clk) begin
		if (rst) begin
			pc <= '0;
			// Zero word decodes as a no-op
			ifIdInstr <= '0;
		end else if (!stall) begin
			pc <= pc + mipsPkg::DataWidth'(4);
			ifIdInstr <= instr;
		end
		// Stall holds both so the dependent instruction is re-decoded
	end

endmodule

// File: design/hazardUnit.sv
// Forwarding selects for execute and load-use stall detection
`timescale 1ns/100ps

module hazardUnit (
	input logic [mipsPkg::DataWidth-1:0] ifIdInstr,
	input mipsPkg::idExT idEx,
	input mipsPkg::exMemT exMem,
	input mipsPkg::wbT wb,
	output logic stall,
	output mipsPkg::fwdSelE fwdA,
	output mipsPkg::fwdSelE fwdB
);

	logic loadInEx;

	// Youngest producer wins, EX/MEM before writeback
	function automatic mipsPkg::fwdSelE pickFwd(
		input logic [mipsPkg::RegAddrWidth-1:0] src,
		input mipsPkg::exMemT memRec,
		input mipsPkg::wbT wbRec
	);
		if (memRec.valid && memRec.ctrl.regWrite && memRec.dest == src) begin
			return mipsPkg::fwdMem;
		end
		// wb.valid already implies regWrite and a nonzero index
		if (wbRec.valid && wbRec.regAddr == src) begin
			return mipsPkg::fwdWb;
		end
		return mipsPkg::fwdReg;
	endfunction

	assign fwdA = pickFwd(idEx.rs, exMem, wb);
	assign fwdB = pickFwd(idEx.rt, exMem, wb);

	// Load result exists only after MEM
	assign loadInEx = idEx.valid && idEx.ctrl.memRead && idEx.ctrl.regWrite;

	// Dependent right behind a load waits one cycle
	// The bubble it creates drops stall on the next cycle
	assign stall = loadInEx &&
		(idEx.dest == ifIdInstr[25:21] || idEx.dest == ifIdInstr[20:16]);

endmodule

// File: design/memoryStage.sv
// Data memory, MEM/WB register and writeback select
`timescale 1ns/100ps

module memoryStage #(
	parameter int DataDepth = 16
) (
	input logic Clk,
	input logic rst,
	input mipsPkg::exMemT exMem,
	output mipsPkg::wbT wb
);

	localparam int IdxWidth = $clog2(DataDepth);

	logic [mipsPkg::DataWidth-1:0] mem [DataDepth];
	logic [IdxWidth-1:0] idx;
	logic [mipsPkg::DataWidth-1:0] loadData;
	mipsPkg::memWbT memWb;

	// Word index from the bits just above the byte offset
	assign idx = exMem.aluResult[IdxWidth+1:2];

	// Store at the clock edge
	always_ff @(posedge Clk) begin
		if (exMem.valid && exMem.ctrl.memWrite) begin
			mem[idx] <= exMem.storeData;
		end
	end

	// Asynchronous read
	assign loadData = mem[idx];

	// MEM/WB register
	always_ff @(posedge Clk) begin
		if (rst) begin
			memWb.valid <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
		end else begin
			memWb.valid <= exMem.valid;
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.memToReg <= exMem.ctrl.memToReg;
		end
		memWb.aluResult <= exMem.aluResult;
		memWb.loadData <= loadData;
		memWb.dest <= exMem.dest;
	end

	// Writeback report drives the register file and the core output
	assign wb.valid = memWb.valid && memWb.regWrite;
	assign wb.regAddr = memWb.dest;
	assign wb.data = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

// File: design/mipsCore.sv
// Five-stage MIPS integer core top level
// Chains fetch, decode, execute and memory with the hazard unit
`timescale 1ns/100ps

module mipsCore #(
	parameter int DataDepth = 16
) (
	input logic Clk,
	input logic rst,
	// Instruction memory lives outside the core
	output logic [mipsPkg::DataWidth-1:0] fetchAddr,
	input logic [mipsPkg::DataWidth-1:0] instr,
	// One pulse per register write
	output mipsPkg::wbT wb
);

	// IF/ID instruction word
	logic [mipsPkg::DataWidth-1:0] ifIdInstr;

	// Stage records
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMem;

	// Hazard controls
	logic stall;
	mipsPkg::fwdSelE fwdA;
	mipsPkg::fwdSelE fwdB;

	// Program counter and IF/ID
	fetchStage fetch (
		.Clk       (Clk),
		.rst       (rst),
		.stall     (stall),
		.fetchAddr (fetchAddr),
		.instr     (instr),
		.ifIdInstr (ifIdInstr)
	);

	// Register file, control decode, ID/EX
	decodeStage decode (
		.Clk       (Clk),
		.rst       (rst),
		.stall     (stall),
		.ifIdInstr (ifIdInstr),
		.wb        (wb),
		.idEx      (idEx)
	);

	// Forwarding and load-use detection
	hazardUnit hazard (
		.ifIdInstr (ifIdInstr),
		.idEx      (idEx),
		.exMem     (exMem),
		.wb        (wb),
		.stall     (stall),
		.fwdA      (fwdA),
		.fwdB      (fwdB)
	);

	// ALU and EX/MEM
	executeStage execute (
		.Clk   (Clk),
		.rst   (rst),
		.idEx  (idEx),
		.fwdA  (fwdA),
		.fwdB  (fwdB),
		.exMem (exMem),
		.wb    (wb)
	);

	// Data memory, MEM/WB and writeback select
	memoryStage #(
		.DataDepth (DataDepth)
	) memory (
		.Clk   (Clk),
		.rst   (rst),
		.exMem (exMem),
		.wb    (wb)
	);

endmodule

// File: design/mipsPkg.sv
// Shared widths, instruction and ALU encodings, forwarding selects
// and the pipeline register records of the five-stage core
package mipsPkg;

	// Machine word and register file geometry
	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int NumRegs = 32;

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeE;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functE;

	// Operation applied by the execute stage ALU
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpE;

	// Operand source picked in execute
	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdMem = 2'd1,
		fwdWb  = 2'd2
	} fwdSelE;

	// Decoded control, all zero for a bubble
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc;
		aluOpE aluOp;
	} ctrlT;

	// ID/EX record
	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [DataWidth-1:0] readData1;
		logic [DataWidth-1:0] readData2;
		logic [DataWidth-1:0] imm;
		logic [RegAddrWidth-1:0] rs;
		logic [RegAddrWidth-1:0] rt;
		logic [RegAddrWidth-1:0] dest;
	} idExT;

	// EX/MEM record
	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [DataWidth-1:0] aluResult;
		logic [DataWidth-1:0] storeData;
		logic [RegAddrWidth-1:0] dest;
	} exMemT;

	// MEM/WB record
	typedef struct packed {
		logic valid;
		logic regWrite;
		logic memToReg;
		logic [DataWidth-1:0] aluResult;
		logic [DataWidth-1:0] loadData;
		logic [RegAddrWidth-1:0] dest;
	} memWbT;

	// Register write report
	typedef struct packed {
		logic valid;
		logic [RegAddrWidth-1:0] regAddr;
		logic [DataWidth-1:0] data;
	} wbT;

endpackage

// File: mipsCore.f
design/mipsPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
verification/clockGen.sv
verification/coreChecker.sv
verification/mipsCore_sva.sv
verification/tbTop.sv

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTop -f mipsCore.f -o simTop

# Assertion errors keep the run going so the testbench reaches its verdict
output=$(./obj_dir/simTop +verilator+error+limit+1000 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

// File: verification/clockGen.sv
// Testbench clock and synchronous reset source
`timescale 1ns/100ps

module clockGen #(
	parameter int HalfPeriod = 4,
	parameter int ResetCycles = 3
) (
	output logic Clk,
	output logic rst
);

	// 8 ns period
	initial begin
		Clk = 1'b0;
		forever #HalfPeriod Clk = ~Clk;
	end

	// Release lands just after a rising edge
	initial begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge Clk);
		#1;
		rst = 1'b0;
	end

endmodule

// File: verification/coreChecker.sv
// In-order instruction-set model of the program and writeback comparison
// with one report line per test
`timescale 1ns/100ps

module coreChecker #(
	parameter int DataDepth = 16,
	parameter int ProgLen = 324
) (
	input logic Clk,
	input logic rst,
	input logic progReady,
	input logic [mipsPkg::DataWidth-1:0] prog [ProgLen],
	input logic [mipsPkg::DataWidth-1:0] fetchAddr,
	input mipsPkg::wbT wb,
	output logic done,
	output int testsRun,
	output int testsFailed,
	output int pulseCount,
	output int expectCount
);

	// One expected register write
	typedef struct packed {
		logic isLoad;
		logic [4:0] regAddr;
		logic [31:0] data;
	} expectT;

	expectT expQ[$];

	int resetErrs;
	int resetChecks;
	int aluErrs;
	int aluChecks;
	int loadErrs;
	int loadChecks;
	int r0Errs;
	int countErrs;
	logic resetDone;

	// Runs the program in order, r0 writes dropped
	task automatic buildExpected();
		logic [31:0] regs [32];
		logic [31:0] dmem [DataDepth];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [4:0] dst;
		logic write;
		logic isLoad;
		int idx;
		expectT e;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < DataDepth; i++) dmem[i] = '0;
		for (int i = 0; i < ProgLen; i++) begin
			w = prog[i];
			a = regs[w[25:21]];
			b = regs[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			// Word index wraps on the data memory size
			idx = int'(((a + imm) >> 2) % 32'(DataDepth));
			write = 1'b0;
			isLoad = 1'b0;
			res = '0;
			dst = w[20:16];
			case (w[31:26])
				mipsPkg::opRType: begin
					dst = w[15:11];
					write = 1'b1;
					case (w[5:0])
						mipsPkg::fnAdd: res = a + b;
						mipsPkg::fnSub: res = a - b;
						mipsPkg::fnAnd: res = a & b;
						mipsPkg::fnOr: res = a | b;
						mipsPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: write = 1'b0;
					endcase
				end
				mipsPkg::opAddi: begin
					res = a + imm;
					write = 1'b1;
				end
				mipsPkg::opLw: begin
					res = dmem[idx];
					write = 1'b1;
					isLoad = 1'b1;
				end
				mipsPkg::opSw: dmem[idx] = b;
				default: write = 1'b0;
			endcase
			if (write && dst != 5'd0) begin
				regs[dst] = res;
				e.isLoad = isLoad;
				e.regAddr = dst;
				e.data = res;
				expQ.push_back(e);
			end
		end
		expectCount = expQ.size();
	endtask

	task automatic reportTest(input string name, input int errs, input int checks);
		testsRun++;
		if (errs == 0) begin
			$display("Test %s: ok, %0d checks", name, checks);
		end else begin
			testsFailed++;
			$display("Test %s: failed, %0d errors in %0d checks", name, errs, checks);
		end
	endtask

	// Quiet writeback and PC at 0
	task automatic checkReset();
		resetChecks++;
		if (wb.valid !== 1'b0 || fetchAddr !== '0) begin
			resetErrs++;
			$display("Error at %0t: wb.valid %b, fetchAddr %h around reset",
				$realtime, wb.valid, fetchAddr);
		end
	endtask

	// Pulses must follow the model's write order
	task automatic checkPulse();
		expectT e;
		pulseCount++;
		if (wb.regAddr == 5'd0) begin
			r0Errs++;
			$display("Error at %0t: writeback names r0 with data %h", $realtime, wb.data);
		end
		if (expQ.size() == 0) begin
			r0Errs++;
			$display("Extra writeback to r%0d after the model ran out of register writes",
				wb.regAddr);
		end else begin
			e = expQ.pop_front();
			if (e.isLoad) loadChecks++;
			else aluChecks++;
			if (wb.regAddr !== e.regAddr || wb.data !== e.data) begin
				if (e.isLoad) loadErrs++;
				else aluErrs++;
				$display("Error at %0t: wb r%0d = %h, model expects r%0d = %h",
					$realtime, wb.regAddr, wb.data, e.regAddr, e.data);
			end
		end
	endtask

	task automatic finishRun();
		reportTest("alu and addi results", aluErrs, aluChecks);
		reportTest("load results", loadErrs, loadChecks);
		reportTest("r0 and no-op writes", r0Errs, pulseCount);
		if (pulseCount != expectCount) begin
			countErrs++;
			$display("Writeback count is wrong: %0d pulses seen, model has %0d writes",
				pulseCount, expectCount);
		end
		reportTest("writeback count", countErrs, 1);
		done = 1'b1;
	endtask

	// Sampled on the falling edge, away from register updates
	initial begin
		done = 1'b0;
		testsRun = 0;
		testsFailed = 0;
		pulseCount = 0;
		expectCount = 0;
		resetErrs = 0;
		resetChecks = 0;
		aluErrs = 0;
		aluChecks = 0;
		loadErrs = 0;
		loadChecks = 0;
		r0Errs = 0;
		countErrs = 0;
		resetDone = 1'b0;
		wait (progReady === 1'b1);
		buildExpected();
		@(posedge Clk);
		forever begin
			@(negedge Clk);
			if (rst) begin
				checkReset();
			end else if (!resetDone) begin
				// First cycle out of reset
				checkReset();
				resetDone = 1'b1;
				reportTest("reset", resetErrs, resetChecks);
			end else if (!done) begin
				if (wb.valid) checkPulse();
				// Epilogue fetched means the body has drained
				if (fetchAddr >= 32'(4 * ProgLen)) finishRun();
			end
		end
	end

endmodule

// File: verification/mipsCore_sva.sv
// Bound assertions on stall, bubble insertion and writeback
`timescale 1ns/100ps

module mipsCore_sva (
	input logic Clk,
	input logic rst,
	input logic stall,
	input logic [mipsPkg::DataWidth-1:0] fetchAddr,
	input mipsPkg::idExT idEx,
	input mipsPkg::wbT wb
);

	// Per-assertion failure tallies
	int stallFails = 0;
	int bubbleFails = 0;
	int holdFails = 0;
	int r0Fails = 0;
	int resetFails = 0;
	int failCount;

	assign failCount = stallFails + bubbleFails + holdFails + r0Fails + resetFails;

	// One stall cycle per load-use pair
	stallOneCycle: assert property (@(posedge Clk) disable iff (rst) stall |=> !stall)
		else begin
			$error("stall stayed high for a second cycle");
			stallFails++;
		end

	// Stall leaves a zero-control bubble in ID/EX
	bubbleOnStall: assert property (@(posedge Clk) disable iff (rst)
		stall |=> (!idEx.valid && idEx.ctrl == '0))
		else begin
			$error("ID/EX not a bubble after stall");
			bubbleFails++;
		end

	pcHeldOnStall: assert property (@(posedge Clk) disable iff (rst)
		stall |=> $stable(fetchAddr))
		else begin
			$error("fetch address moved during stall");
			holdFails++;
		end

	noR0Write: assert property (@(posedge Clk) disable iff (rst) wb.valid |-> wb.regAddr != '0)
		else begin
			$error("writeback to r0");
			r0Fails++;
		end

	quietAfterReset: assert property (@(posedge Clk) rst |=> !wb.valid)
		else begin
			$error("writeback pulse right after reset");
			resetFails++;
		end

endmodule

bind mipsCore mipsCore_sva svaChecks (
	.Clk       (Clk),
	.rst       (rst),
	.stall     (stall),
	.fetchAddr (fetchAddr),
	.idEx      (idEx),
	.wb        (wb)
);

// File: verification/tbTop.sv
// Testbench top with random program, instruction memory, DUT,
// checker and cycle-limited run control
`timescale 1ns/100ps

module tbTop;

	localparam int DataDepth = 16;
	localparam int BodyLen = 300;
	localparam int EpilogueLen = 8;
	localparam int ProgLen = DataDepth + BodyLen + EpilogueLen;
	// Twice the program plus slack for reset and drain
	localparam int TimeoutCycles = 2 * ProgLen + 40;

	logic Clk;
	logic rst;
	logic [mipsPkg::DataWidth-1:0] fetchAddr;
	logic [mipsPkg::DataWidth-1:0] instr;
	mipsPkg::wbT wb;

	logic [mipsPkg::DataWidth-1:0] prog [ProgLen];
	logic progReady;
	logic [31:0] rndState;
	int cycles = 0;

	logic done;
	int testsRun;
	int testsFailed;
	int pulseCount;
	int expectCount;

	clockGen clkGen (
		.Clk (Clk),
		.rst (rst)
	);

	mipsCore #(
		.DataDepth (DataDepth)
	) uut (
		.Clk       (Clk),
		.rst       (rst),
		.fetchAddr (fetchAddr),
		.instr     (instr),
		.wb        (wb)
	);

	coreChecker #(
		.DataDepth (DataDepth),
		.ProgLen   (ProgLen)
	) coreCheck (
		.Clk         (Clk),
		.rst         (rst),
		.progReady   (progReady),
		.prog        (prog),
		.fetchAddr   (fetchAddr),
		.wb          (wb),
		.done        (done),
		.testsRun    (testsRun),
		.testsFailed (testsFailed),
		.pulseCount  (pulseCount),
		.expectCount (expectCount)
	);

	// 32-bit xorshift step
	function automatic logic [31:0] nextRand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Mostly r0..r7 so dependencies stay dense
	function automatic logic [4:0] regFrom(input logic [31:0] r);
		return (r[7:5] != 3'd0) ? {2'b00, r[2:0]} : r[12:8];
	endfunction

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Prologue clears data memory, body is random, epilogue is no-ops
	task automatic buildProgram();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		int kind;
		for (int i = 0; i < DataDepth; i++) begin
			prog[i] = encodeI(mipsPkg::opSw, 5'd0, 5'd0, 16'(4 * i));
		end
		for (int i = DataDepth; i < DataDepth + BodyLen; i++) begin
			rndState = nextRand(rndState);
			rs = regFrom(rndState);
			rt = regFrom(rndState >> 13);
			rd = regFrom(rndState >> 19);
			rndState = nextRand(rndState);
			imm = rndState[15:0];
			kind = int'(rndState[31:16] % 16'd20);
			case (kind)
				0, 1: prog[i] = encodeR(rs, rt, rd, mipsPkg::fnAdd);
				2, 19: prog[i] = encodeR(rs, rt, rd, mipsPkg::fnSub);
				3: prog[i] = encodeR(rs, rt, rd, mipsPkg::fnAnd);
				4: prog[i] = encodeR(rs, rt, rd, mipsPkg::fnOr);
				5: prog[i] = encodeR(rs, rt, rd, mipsPkg::fnSlt);
				6, 7, 8: prog[i] = encodeI(mipsPkg::opAddi, rs, rt, imm);
				9, 10, 11, 12: prog[i] = encodeI(mipsPkg::opLw, rs, rt, imm);
				13, 14, 15: prog[i] = encodeI(mipsPkg::opSw, rs, rt, imm);
				// Unknown opcode
				17: prog[i] = encodeI(6'h3f, rs, rt, imm);
				// Unknown function code
				18: prog[i] = encodeR(rs, rt, rd, 6'h3f);
				default: prog[i] = '0;
			endcase
		end
		for (int i = DataDepth + BodyLen; i < ProgLen; i++) begin
			prog[i] = '0;
		end
	endtask

	// Word at the fetch address, no-op past the end
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < ProgLen) begin
			return prog[idx];
		end
		return '0;
	endfunction

	// Instruction memory follows fetchAddr 1 ns after each edge
	initial begin
		instr = '0;
		progReady = 1'b0;
		rndState = 32'hea05cc12;
		buildProgram();
		progReady = 1'b1;
		forever begin
			@(posedge Clk);
			#1;
			instr = fetchWord(fetchAddr);
		end
	end

	// Run control and final verdict
	always @(posedge Clk) begin
		cycles++;
		if (done === 1'b1) begin
			$display("Summary: %0d tests, %0d failed, %0d of %0d writebacks, %0d assertion failures",
				testsRun, testsFailed, pulseCount, expectCount, uut.svaChecks.failCount);
			if (testsFailed == 0 && uut.svaChecks.failCount == 0) begin
				$display("*** PASSED ***");
			end else begin
				$display("*** FAILED ***");
			end
			$finish;
		end else if (cycles >= TimeoutCycles) begin
			$display("Timeout: run stopped after %0d cycles with %0d of %0d writebacks seen",
				cycles, pulseCount, expectCount);
			$display("*** FAILED ***");
			$finish;
		end
	end

endmodule
